// ==== design/counter_pkg.sv ====
package counter_pkg;

    // --------------------------------------------------
    // Sizes
    // --------------------------------------------------
    localparam int NUM_DIGITS  = 5;
    // "BTN " prefix, up to five digits, newline
    localparam int MSG_MAX_LEN = 4 + NUM_DIGITS + 1;

    // --------------------------------------------------
    // Basic types
    // --------------------------------------------------
    typedef logic [7:0] uart_byte_t;
    typedef logic [3:0] bcd_digit_t;

    // Ones digit sits in digit[0]
    typedef struct packed {
        bcd_digit_t [NUM_DIGITS-1:0] digit;
    } bcd_count_t;

    // Byte request from sequencer to UART transmitter
    typedef struct packed {
        logic       start;
        uart_byte_t data;
    } tx_req_t;

    // --------------------------------------------------
    // ASCII codes used in the text line
    // --------------------------------------------------
    localparam uart_byte_t CHAR_B       = 8'h42;
    localparam uart_byte_t CHAR_T       = 8'h54;
    localparam uart_byte_t CHAR_N       = 8'h4e;
    localparam uart_byte_t CHAR_SPACE   = 8'h20;
    localparam uart_byte_t CHAR_ZERO    = 8'h30;
    localparam uart_byte_t CHAR_NEWLINE = 8'h0a;

endpackage

// ==== design/button_debouncer.sv ====
`timescale 1ns/1ps

module button_debouncer #(
    parameter int DEBOUNCE_BITS = 18
) (
    input  logic clk,
    input  logic rst,
    input  logic btn_n,
    output logic pressed
);

    // --------------------------------------------------
    // Synchronizer
    // --------------------------------------------------
    logic sync_0;
    logic sync_1;
    logic btn_level;

    // Idle button reads high, so flops reset to released
    always_ff @(posedge clk) begin
        if (rst) begin
            sync_0 <= 1'b1;
            sync_1 <= 1'b1;
        end else begin
            sync_0 <= btn_n;
            sync_1 <= sync_0;
        end
    end

    // Active high from here on
    assign btn_level = ~sync_1;

    // --------------------------------------------------
    // Stability filter
    // --------------------------------------------------
    logic [DEBOUNCE_BITS-1:0] db_cnt;
    logic                     stable;
    logic                     stable_d;

    // New level accepted after 2^DEBOUNCE_BITS cycles of disagreement
    always_ff @(posedge clk) begin
        if (rst) begin
            db_cnt <= '0;
            stable <= 1'b0;
        end else if (btn_level != stable) begin
            if (db_cnt == {DEBOUNCE_BITS{1'b1}}) begin
                stable <= btn_level;
                db_cnt <= '0;
            end else begin
                db_cnt <= db_cnt + 1'b1;
            end
        end else begin
            // Any glitch back to the old level restarts the wait
            db_cnt <= '0;
        end
    end

    // Rising edge of the filtered level
    always_ff @(posedge clk) begin
        if (rst) begin
            stable_d <= 1'b0;
            pressed  <= 1'b0;
        end else begin
            stable_d <= stable;
            pressed  <= stable && !stable_d;
        end
    end

    a_single_cycle_press: assert property (@(posedge clk) disable iff (rst)
        pressed |=> !pressed)
        else $error("pressed held high for more than one cycle");

endmodule

// ==== design/bcd_press_counter.sv ====
`timescale 1ns/1ps

module bcd_press_counter (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pressed,
    input  logic                    ready,
    output counter_pkg::bcd_count_t count,
    output logic                    count_valid
);

    import counter_pkg::*;

    logic       accept;
    logic       carry;
    bcd_count_t count_next;

    // Presses while a line is in flight are dropped
    assign accept = pressed && ready;

    // --------------------------------------------------
    // Ripple carry increment
    // --------------------------------------------------
    always_comb begin
        carry      = 1'b1;
        count_next = count;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            if (carry) begin
                if (count.digit[i] == bcd_digit_t'(9)) begin
                    // Roll over, carry moves up one digit
                    count_next.digit[i] = '0;
                end else begin
                    count_next.digit[i] = count.digit[i] + 1'b1;
                    carry               = 1'b0;
                end
            end
        end
        // Carry out of the top digit is lost, 99999 wraps to 0
    end

    // --------------------------------------------------
    // Count register
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            count       <= '0;
            count_valid <= 1'b0;
        end else begin
            count_valid <= accept;
            if (accept) begin
                count <= count_next;
            end
        end
    end

    // Every digit stays decimal
    for (genvar g = 0; g < NUM_DIGITS; g++) begin : g_digit_chk
        a_digit_decimal: assert property (@(posedge clk) disable iff (rst)
            count.digit[g] <= bcd_digit_t'(9))
            else $error("BCD digit %0d out of range: %0d", g, count.digit[g]);
    end

endmodule

// ==== design/message_sequencer.sv ====
`timescale 1ns/1ps

module message_sequencer (
    input  logic                    clk,
    input  logic                    rst,
    input  counter_pkg::bcd_count_t count,
    input  logic                    count_valid,
    input  logic                    busy,
    output counter_pkg::tx_req_t    tx_req,
    output logic                    ready
);

    import counter_pkg::*;

    localparam int PREFIX_LEN = 4;
    localparam int IDX_W      = $clog2(MSG_MAX_LEN);

    typedef logic [IDX_W-1:0] idx_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT_HI,
        S_WAIT_LO
    } state_t;

    state_t     state;
    uart_byte_t msg_buf   [MSG_MAX_LEN];
    uart_byte_t line_next [MSG_MAX_LEN];
    idx_t       num_sig;
    idx_t       cur_idx;
    idx_t       next_idx;
    idx_t       last_idx;

    function automatic uart_byte_t to_ascii(input bcd_digit_t d);
        return CHAR_ZERO + uart_byte_t'(d);
    endfunction

    // --------------------------------------------------
    // Line formatting
    // --------------------------------------------------

    // Number of significant digits, at least one
    always_comb begin
        num_sig = idx_t'(1);
        for (int i = 1; i < NUM_DIGITS; i++) begin
            if (count.digit[i] != '0) begin
                num_sig = idx_t'(i + 1);
            end
        end
    end

    always_comb begin
        line_next[0] = CHAR_B;
        line_next[1] = CHAR_T;
        line_next[2] = CHAR_N;
        line_next[3] = CHAR_SPACE;
        for (int p = PREFIX_LEN; p < MSG_MAX_LEN; p++) begin
            line_next[p] = CHAR_NEWLINE;
        end
        // Most significant digit first
        for (int p = 0; p < NUM_DIGITS; p++) begin
            if (p < int'(num_sig)) begin
                line_next[PREFIX_LEN + p] = to_ascii(count.digit[int'(num_sig) - 1 - p]);
            end
        end
    end

    // --------------------------------------------------
    // Byte stepping FSM
    // --------------------------------------------------
    assign next_idx = cur_idx + 1'b1;
    assign ready    = (state == S_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= S_IDLE;
            cur_idx      <= '0;
            last_idx     <= '0;
            tx_req.start <= 1'b0;
        end else begin
            tx_req.start <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (count_valid) begin
                        msg_buf      <= line_next;
                        last_idx     <= idx_t'(PREFIX_LEN) + num_sig;
                        cur_idx      <= '0;
                        // First byte goes out right away
                        tx_req.start <= 1'b1;
                        tx_req.data  <= line_next[0];
                        state        <= S_WAIT_HI;
                    end
                end

                // Transmitter has taken the byte once busy rises
                S_WAIT_HI: begin
                    if (busy) begin
                        state <= S_WAIT_LO;
                    end
                end

                S_WAIT_LO: begin
                    if (!busy) begin
                        if (cur_idx == last_idx) begin
                            // Newline frame done
                            state <= S_IDLE;
                        end else begin
                            cur_idx      <= next_idx;
                            tx_req.start <= 1'b1;
                            tx_req.data  <= msg_buf[next_idx];
                            state        <= S_WAIT_HI;
                        end
                    end
                end

                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// ==== design/uart_transmitter.sv ====
`timescale 1ns/1ps

module uart_transmitter #(
    parameter int CLOCK_HZ = 25_000_000,
    parameter int BAUD     = 115_200
) (
    input  logic                 clk,
    input  logic                 rst,
    input  counter_pkg::tx_req_t tx_req,
    output logic                 busy,
    output logic                 tx
);

    localparam int DIVISOR    = CLOCK_HZ / BAUD;
    localparam int CNT_W      = (DIVISOR > 1) ? $clog2(DIVISOR) : 1;
    localparam int FRAME_BITS = 10;

    logic [CNT_W-1:0]      baud_cnt;
    logic [3:0]            bit_cnt;
    logic [FRAME_BITS-1:0] shifter;
    logic                  baud_tick;

    // --------------------------------------------------
    // Baud divider
    // --------------------------------------------------
    assign baud_tick = (baud_cnt == '0);

    // Restarts with every frame so each bit is DIVISOR cycles wide
    always_ff @(posedge clk) begin
        if (rst) begin
            baud_cnt <= CNT_W'(DIVISOR - 1);
        end else if (!busy || baud_tick) begin
            baud_cnt <= CNT_W'(DIVISOR - 1);
        end else begin
            baud_cnt <= baud_cnt - 1'b1;
        end
    end

    // --------------------------------------------------
    // Frame shifter
    // --------------------------------------------------
    // Bit 0 drives the line, ones fill in behind
    assign tx = shifter[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            shifter <= '1;
        end else if (!busy) begin
            if (tx_req.start) begin
                // Stop bit, data LSB first, start bit
                shifter <= {1'b1, tx_req.data, 1'b0};
                bit_cnt <= '0;
                busy    <= 1'b1;
            end
        end else if (baud_tick) begin
            shifter <= {1'b1, shifter[FRAME_BITS-1:1]};
            if (bit_cnt == 4'(FRAME_BITS - 1)) begin
                // Stop bit has had its full period
                busy <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    a_no_start_when_busy: assert property (@(posedge clk) disable iff (rst)
        busy |-> !tx_req.start)
        else $error("UART start request while frame in progress");

endmodule

// ==== design/super_counter_top.sv ====
`timescale 1ns/1ps

module super_counter_top #(
    parameter int CLOCK_HZ      = 25_000_000,
    parameter int BAUD          = 115_200,
    parameter int DEBOUNCE_BITS = 18
) (
    input  logic clk,
    input  logic rst,
    input  logic btn_n,
    output logic tx
);

    import counter_pkg::*;

    logic       pressed;
    bcd_count_t count;
    logic       count_valid;
    logic       ready;
    tx_req_t    tx_req;
    logic       busy;

    // --------------------------------------------------
    // Button to count
    // --------------------------------------------------
    button_debouncer #(
        .DEBOUNCE_BITS(DEBOUNCE_BITS)
    ) u_debouncer (
        .clk    (clk),
        .rst    (rst),
        .btn_n  (btn_n),
        .pressed(pressed)
    );

    bcd_press_counter u_counter (
        .clk        (clk),
        .rst        (rst),
        .pressed    (pressed),
        .ready      (ready),
        .count      (count),
        .count_valid(count_valid)
    );

    // --------------------------------------------------
    // Count to serial line
    // --------------------------------------------------
    message_sequencer u_sequencer (
        .clk        (clk),
        .rst        (rst),
        .count      (count),
        .count_valid(count_valid),
        .busy       (busy),
        .tx_req     (tx_req),
        .ready      (ready)
    );

    uart_transmitter #(
        .CLOCK_HZ(CLOCK_HZ),
        .BAUD    (BAUD)
    ) u_uart_tx (
        .clk   (clk),
        .rst   (rst),
        .tx_req(tx_req),
        .busy  (busy),
        .tx    (tx)
    );

endmodule

// ==== verif/uart_line_monitor.sv ====
`timescale 1ns/1ps

module uart_line_monitor #(
    parameter int CYCLES_PER_BIT = 8
) (
    input  logic clk,
    input  logic tx
);

    import counter_pkg::*;

    // --------------------------------------------------
    // Decoded frame for the testbench
    // --------------------------------------------------
    uart_byte_t rx_byte;
    logic       start_ok;
    logic       stop_ok;

    // Fires once a whole frame has been sampled
    event byte_done;

    // Entered half a cycle into the start bit
    task automatic receive_frame();
        uart_byte_t data;
        data = '0;
        // Middle of the start bit
        repeat (CYCLES_PER_BIT / 2 - 1) @(negedge clk);
        start_ok = (tx === 1'b0);
        // Data bits in LSB first order
        for (int i = 0; i < 8; i++) begin
            repeat (CYCLES_PER_BIT) @(negedge clk);
            data[i] = tx;
        end
        // Middle of the stop bit
        repeat (CYCLES_PER_BIT) @(negedge clk);
        stop_ok = (tx === 1'b1);
        rx_byte = data;
        -> byte_done;
    endtask

    // --------------------------------------------------
    // Start bit search
    // --------------------------------------------------
    // Falling edge sampling keeps clear of the register updates
    initial begin
        rx_byte  = '0;
        start_ok = 1'b1;
        stop_ok  = 1'b1;
        forever begin
            @(negedge clk);
            if (tx === 1'b0) begin
                receive_frame();
            end
        end
    end

endmodule

// ==== verif/tb_super_counter.sv ====
`timescale 1ns/1ps

module tb_super_counter;

    import counter_pkg::*;

    localparam int CLOCK_HZ        = 25_000_000;
    localparam int BAUD            = 3_125_000;
    localparam int DEBOUNCE_BITS   = 4;
    localparam int CYCLES_PER_BIT  = CLOCK_HZ / BAUD;
    localparam logic [31:0] SEED   = 32'hdf1c270d;
    // Longer than the debounce window with some room
    localparam int SETTLE_CYCLES   = (1 << DEBOUNCE_BITS) + 8;
    localparam int MAX_BOUNCES     = 6;
    // Ten bits per frame plus the start/busy handshake
    localparam int LINE_CYCLES     = MSG_MAX_LEN * (10 * CYCLES_PER_BIT + 4);
    localparam int PRESS_CYCLES    = 2 * (MAX_BOUNCES * 20 + SETTLE_CYCLES);
    localparam int PLANNED_PRESSES = 101;
    localparam int WATCHDOG_CYCLES = PLANNED_PRESSES * (LINE_CYCLES + PRESS_CYCLES) + 5000;

    logic        clk;
    logic        rst;
    logic        btn_n;
    logic        tx;
    logic        expect_idle;
    logic [31:0] lfsr;
    uart_byte_t  exp_q[$];
    uart_byte_t  exp_byte;
    int          model_count;
    int          mismatch_errors;
    int          framing_errors;
    int          other_errors;

    super_counter_top #(
        .CLOCK_HZ     (CLOCK_HZ),
        .BAUD         (BAUD),
        .DEBOUNCE_BITS(DEBOUNCE_BITS)
    ) dut (
        .clk  (clk),
        .rst  (rst),
        .btn_n(btn_n),
        .tx   (tx)
    );

    uart_line_monitor #(
        .CYCLES_PER_BIT(CYCLES_PER_BIT)
    ) mon (
        .clk(clk),
        .tx (tx)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // --------------------------------------------------
    // Random glitch lengths
    // --------------------------------------------------
    // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic int draw_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_bit());
        end
        return v;
    endfunction

    // 1 to 10 cycles, always under the debounce window
    function automatic int glitch_len();
        return 1 + (draw_bits(4) % 10);
    endfunction

    // --------------------------------------------------
    // Stimulus and reference model
    // --------------------------------------------------
    task automatic hold_level(input logic level, input int cycles);
        btn_n = level;
        repeat (cycles) @(negedge clk);
    endtask

    task automatic queue_line(input int n);
        string s;
        s = $sformatf("BTN %0d\n", n);
        for (int i = 0; i < s.len(); i++) begin
            exp_q.push_back(uart_byte_t'(s[i]));
        end
    endtask

    task automatic press_button(input int bounces);
        // A press only counts when no line is on the wire
        if (exp_q.size() == 0) begin
            model_count = (model_count + 1) % 100000;
            queue_line(model_count);
        end
        for (int i = 0; i < bounces; i++) begin
            hold_level(1'b0, glitch_len());
            hold_level(1'b1, glitch_len());
        end
        hold_level(1'b0, SETTLE_CYCLES);
        for (int i = 0; i < bounces; i++) begin
            hold_level(1'b1, glitch_len());
            hold_level(1'b0, glitch_len());
        end
        hold_level(1'b1, SETTLE_CYCLES);
    endtask

    task automatic wait_line_done();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < LINE_CYCLES + PRESS_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Line not finished after %0d cycles, %0d bytes never arrived",
                     waited, exp_q.size());
            other_errors++;
            exp_q.delete();
        end
        // Stop bit ends and the sequencer goes back to ready
        repeat (CYCLES_PER_BIT) @(negedge clk);
    endtask

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    a_idle_line: assert property (@(posedge clk) disable iff (rst) expect_idle |-> tx)
        else begin
            $display("Serial line went low at %0t while the button was idle", $time);
            other_errors++;
        end

    always @(mon.byte_done) begin
        if (exp_q.size() == 0) begin
            $display("Byte 0x%02h arrived at %0t with no line pending", mon.rx_byte, $time);
            other_errors++;
        end else begin
            exp_byte = exp_q.pop_front();
            a_byte_value: assert (mon.rx_byte == exp_byte)
                else begin
                    $display("MISMATCH at %0t: expected 0x%02h, received 0x%02h",
                             $time, exp_byte, mon.rx_byte);
                    mismatch_errors++;
                end
        end
        a_start_bit: assert (mon.start_ok)
            else begin
                $display("Frame at %0t lost its start bit before mid-bit", $time);
                framing_errors++;
            end
        a_stop_bit: assert (mon.stop_ok)
            else begin
                $display("Frame at %0t has no stop bit", $time);
                framing_errors++;
            end
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        rst             = 1'b1;
        btn_n           = 1'b1;
        expect_idle     = 1'b0;
        lfsr            = SEED;
        model_count     = 0;
        mismatch_errors = 0;
        framing_errors  = 0;
        other_errors    = 0;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        // Quiet line after reset, then a lone glitch
        expect_idle = 1'b1;
        repeat (200) @(negedge clk);
        hold_level(1'b0, glitch_len());
        hold_level(1'b1, 200);
        expect_idle = 1'b0;

        // Clean press, then a bouncy one
        press_button(0);
        wait_line_done();
        press_button(MAX_BOUNCES);
        wait_line_done();

        // Second press lands while the line is in flight
        press_button(0);
        @(mon.byte_done);
        press_button(0);
        wait_line_done();
        press_button(2);
        wait_line_done();

        // Through 9, 10, 99 and 100
        while (model_count < 100) begin
            press_button(draw_bits(2));
            wait_line_done();
        end

        $display("Errors: mismatch %0d, framing %0d, other %0d",
                 mismatch_errors, framing_errors, other_errors);
        if (mismatch_errors + framing_errors + other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog sized from the planned presses
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Errors: mismatch %0d, framing %0d, other %0d",
                 mismatch_errors, framing_errors, other_errors + 1);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== vlog.f ====
design/counter_pkg.sv
design/button_debouncer.sv
design/bcd_press_counter.sv
design/message_sequencer.sv
design/uart_transmitter.sv
design/super_counter_top.sv
verif/uart_line_monitor.sv
verif/tb_super_counter.sv
